/* dsp_datapath.f */
hdl/dsp_pkg.sv
hdl/dsp_cfg_regs.sv
hdl/code_history.sv
hdl/ffe_slicer.sv
hdl/channel_error.sv
hdl/sliding_detector.sv
hdl/dsp_datapath_top.sv
sim/tb_dsp_datapath.sv

/* hdl/channel_error.sv */
`default_nettype none

module channel_error (
    input  wire logic                 clk,
    input  wire logic                 rst_n_i,
    input  wire dsp_pkg::bit_group_t  bits_i,
    input  wire dsp_pkg::bit_group_t  bits_prev_i,
    input  wire dsp_pkg::code_group_t codes_i,
    input  wire dsp_pkg::cfg_t        cfg_i,
    output dsp_pkg::err_group_t       err_o,
    output dsp_pkg::bit_group_t       err_bits_o
);

    logic [2*dsp_pkg::lane_count-1:0]          bit_win;
    dsp_pkg::weight_t [dsp_pkg::chan_taps-1:0] hs;
    dsp_pkg::err_group_t                       err_d;
    dsp_pkg::err_group_t                       err_q;
    dsp_pkg::bit_group_t                       bits_q;

    assign bit_win = {bits_i.lane, bits_prev_i.lane};

    always_comb begin
        for (int j = 0; j < dsp_pkg::chan_taps; j++) begin
            hs[j] = $signed(cfg_i.chan_h[j]) >>> cfg_i.chan_shift;
        end
    end

    // Bit 1 adds the tap, bit 0 subtracts it
    always_comb begin
        dsp_pkg::ecode_t est;
        dsp_pkg::ecode_t tap;
        for (int l = 0; l < dsp_pkg::lane_count; l++) begin
            est = '0;
            for (int j = 0; j < dsp_pkg::chan_taps; j++) begin
                tap = dsp_pkg::ecode_t'($signed(hs[j]));
                if (bit_win[dsp_pkg::lane_count + l - j]) begin
                    est = est + tap;
                end else begin
                    est = est - tap;
                end
            end
            err_d.lane[l] = dsp_pkg::err_t'(est)
                          - dsp_pkg::err_t'($signed(codes_i.lane[l]));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            err_q  <= '0;
            bits_q <= '0;
        end else begin
            err_q  <= err_d;
            bits_q <= bits_i;
        end
    end

    assign err_o      = err_q;
    assign err_bits_o = bits_q;

endmodule

`default_nettype wire

/* hdl/code_history.sv */
`default_nettype none

module code_history (
    input  wire logic                 clk,
    input  wire logic                 rst_n_i,
    input  wire dsp_pkg::code_group_t codes_i,
    output dsp_pkg::code_group_t      cur_o,
    output dsp_pkg::code_group_t      prev_o,
    output dsp_pkg::code_group_t      aligned_o
);

    dsp_pkg::code_group_t cur_q;
    dsp_pkg::code_group_t prev_q;
    dsp_pkg::code_group_t aligned_q;

    // prev_q also serves as the second stage of the alignment delay
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            cur_q     <= '0;
            prev_q    <= '0;
            aligned_q <= '0;
        end else begin
            cur_q     <= codes_i;
            prev_q    <= cur_q;
            aligned_q <= prev_q;
        end
    end

    assign cur_o     = cur_q;
    assign prev_o    = prev_q;
    assign aligned_o = aligned_q;

endmodule

`default_nettype wire

/* hdl/dsp_cfg_regs.sv */
`default_nettype none

module dsp_cfg_regs (
    input  wire logic                           clk,
    input  wire logic                           rst_n_i,
    input  wire logic [dsp_pkg::apb_addr_w-1:0] paddr_i,
    input  wire logic                           psel_i,
    input  wire logic                           penable_i,
    input  wire logic                           pwrite_i,
    input  wire logic [dsp_pkg::apb_data_w-1:0] pwdata_i,
    output logic [dsp_pkg::apb_data_w-1:0]      prdata_o,
    output logic                                pready_o,
    output logic                                pslverr_o,
    output dsp_pkg::cfg_t                       cfg_o
);

    dsp_pkg::cfg_t cfg_q;
    logic          addr_hit;
    logic          wr_en;

    // Address decode and read mux
    always_comb begin
        prdata_o = '0;
        addr_hit = 1'b1;
        case (paddr_i)
            dsp_pkg::addr_ffe_w: begin
                prdata_o[dsp_pkg::ffe_taps*dsp_pkg::weight_w-1:0] = cfg_q.ffe_w;
            end
            dsp_pkg::addr_ffe_ctl: begin
                prdata_o[dsp_pkg::shift_w-1:0] = cfg_q.ffe_shift;
                prdata_o[dsp_pkg::thresh_lsb +: dsp_pkg::est_w] = cfg_q.thresh;
            end
            dsp_pkg::addr_chan_h: begin
                prdata_o[dsp_pkg::chan_taps*dsp_pkg::weight_w-1:0] = cfg_q.chan_h;
            end
            dsp_pkg::addr_chan_ctl: begin
                prdata_o[dsp_pkg::shift_w-1:0] = cfg_q.chan_shift;
            end
            default: begin
                addr_hit = 1'b0;
            end
        endcase
    end

    // Zero wait states
    assign pready_o  = 1'b1;
    assign pslverr_o = psel_i && penable_i && !addr_hit;
    assign wr_en     = psel_i && penable_i && pwrite_i && addr_hit;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            cfg_q <= '0;
        end else if (wr_en) begin
            case (paddr_i)
                dsp_pkg::addr_ffe_w: begin
                    cfg_q.ffe_w <= pwdata_i[dsp_pkg::ffe_taps*dsp_pkg::weight_w-1:0];
                end
                dsp_pkg::addr_ffe_ctl: begin
                    cfg_q.ffe_shift <= pwdata_i[dsp_pkg::shift_w-1:0];
                    cfg_q.thresh    <= pwdata_i[dsp_pkg::thresh_lsb +: dsp_pkg::est_w];
                end
                dsp_pkg::addr_chan_h: begin
                    cfg_q.chan_h <= pwdata_i[dsp_pkg::chan_taps*dsp_pkg::weight_w-1:0];
                end
                default: begin
                    cfg_q.chan_shift <= pwdata_i[dsp_pkg::shift_w-1:0];
                end
            endcase
        end
    end

    assign cfg_o = cfg_q;

endmodule

`default_nettype wire

/* hdl/dsp_datapath_top.sv */
`default_nettype none

module dsp_datapath_top (
    input  wire logic                           clk,
    input  wire logic                           rst_n_i,
    input  wire logic [dsp_pkg::apb_addr_w-1:0] paddr_i,
    input  wire logic                           psel_i,
    input  wire logic                           penable_i,
    input  wire logic                           pwrite_i,
    input  wire logic [dsp_pkg::apb_data_w-1:0] pwdata_i,
    output logic [dsp_pkg::apb_data_w-1:0]      prdata_o,
    output logic                                pready_o,
    output logic                                pslverr_o,
    input  wire dsp_pkg::code_group_t           codes_i,
    input  wire logic                           codes_valid_i,
    output dsp_pkg::bit_group_t                 bits_o,
    output dsp_pkg::err_group_t                 err_o,
    output dsp_pkg::det_group_t                 det_o,
    output logic                                out_valid_o
);

    dsp_pkg::cfg_t        cfg;
    dsp_pkg::code_group_t cur;
    dsp_pkg::code_group_t prev;
    dsp_pkg::code_group_t aligned;
    dsp_pkg::bit_group_t  bits;
    dsp_pkg::bit_group_t  bits_prev;
    dsp_pkg::bit_group_t  err_bits;
    dsp_pkg::err_group_t  err;

    dsp_pkg::err_group_t [dsp_pkg::align_depth-1:0] err_dly;
    dsp_pkg::bit_group_t [dsp_pkg::align_depth-1:0] bits_dly;
    logic [dsp_pkg::out_lat-1:0]                    valid_sr;

    dsp_cfg_regs cfg_regs_i (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .paddr_i   (paddr_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .cfg_o     (cfg)
    );

    code_history code_history_i (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .codes_i   (codes_i),
        .cur_o     (cur),
        .prev_o    (prev),
        .aligned_o (aligned)
    );

    ffe_slicer ffe_slicer_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .cur_i       (cur),
        .prev_i      (prev),
        .cfg_i       (cfg),
        .bits_o      (bits),
        .bits_prev_o (bits_prev)
    );

    channel_error channel_error_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .bits_i      (bits),
        .bits_prev_i (bits_prev),
        .codes_i     (aligned),
        .cfg_i       (cfg),
        .err_o       (err),
        .err_bits_o  (err_bits)
    );

    sliding_detector sliding_detector_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .err_i   (err),
        .bits_i  (err_bits),
        .cfg_i   (cfg),
        .det_o   (det_o)
    );

    // Bits travel with their errors from the error stage to the outputs
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            err_dly  <= '0;
            bits_dly <= '0;
            valid_sr <= '0;
        end else begin
            err_dly  <= {err_dly[dsp_pkg::align_depth-2:0], err};
            bits_dly <= {bits_dly[dsp_pkg::align_depth-2:0], err_bits};
            valid_sr <= {valid_sr[dsp_pkg::out_lat-2:0], codes_valid_i};
        end
    end

    assign err_o       = err_dly[dsp_pkg::align_depth-1];
    assign bits_o      = bits_dly[dsp_pkg::align_depth-1];
    assign out_valid_o = valid_sr[dsp_pkg::out_lat-1];

endmodule

`default_nettype wire

/* hdl/dsp_pkg.sv */
`default_nettype none

package dsp_pkg;

    localparam int lane_count = 4;
    localparam int code_w     = 8;
    localparam int weight_w   = 8;
    localparam int ffe_taps   = 3;
    localparam int chan_taps  = 3;
    localparam int shift_w    = 3;
    localparam int est_w      = 10;
    localparam int ecode_w    = 10;
    localparam int err_w      = 11;
    localparam int cost_w     = 24;

    // Full precision FFE sum, and e - 2*s*hs in the detector
    localparam int ffe_acc_w  = code_w + weight_w + 2;
    localparam int diff_w     = err_w + 1;

    // Latency from codes_i to the error register and to the outputs
    localparam int err_lat     = 4;
    localparam int out_lat     = 6;
    localparam int align_depth = out_lat - err_lat;

    localparam int apb_addr_w = 8;
    localparam int apb_data_w = 32;
    localparam int thresh_lsb = 16;

    localparam logic [apb_addr_w-1:0] addr_ffe_w    = 8'h00;
    localparam logic [apb_addr_w-1:0] addr_ffe_ctl  = 8'h04;
    localparam logic [apb_addr_w-1:0] addr_chan_h   = 8'h08;
    localparam logic [apb_addr_w-1:0] addr_chan_ctl = 8'h0C;

    typedef logic signed [code_w-1:0]    code_t;
    typedef logic signed [weight_w-1:0]  weight_t;
    typedef logic signed [est_w-1:0]     est_t;
    typedef logic signed [ecode_w-1:0]   ecode_t;
    typedef logic signed [err_w-1:0]     err_t;
    typedef logic signed [cost_w-1:0]    cost_t;
    typedef logic signed [ffe_acc_w-1:0] ffe_acc_t;
    typedef logic signed [diff_w-1:0]    diff_t;
    typedef logic [shift_w-1:0]          shift_t;

    typedef struct packed {
        code_t [lane_count-1:0] lane;
    } code_group_t;

    typedef struct packed {
        weight_t [ffe_taps-1:0]  ffe_w;
        shift_t                  ffe_shift;
        est_t                    thresh;
        weight_t [chan_taps-1:0] chan_h;
        shift_t                  chan_shift;
    } cfg_t;

    typedef struct packed {
        logic [lane_count-1:0] lane;
    } bit_group_t;

    typedef struct packed {
        err_t [lane_count-1:0] lane;
    } err_group_t;

    typedef enum logic [1:0] {
        det_none      = 2'd0,
        det_flip_cur  = 2'd1,
        det_flip_next = 2'd2
    } det_e;

    typedef struct packed {
        det_e [lane_count-1:0] lane;
    } det_group_t;

endpackage

`default_nettype wire

/* hdl/ffe_slicer.sv */
`default_nettype none

module ffe_slicer (
    input  wire logic                 clk,
    input  wire logic                 rst_n_i,
    input  wire dsp_pkg::code_group_t cur_i,
    input  wire dsp_pkg::code_group_t prev_i,
    input  wire dsp_pkg::cfg_t        cfg_i,
    output dsp_pkg::bit_group_t       bits_o,
    output dsp_pkg::bit_group_t       bits_prev_o
);

    // Oldest sample in index 0, current group in the upper lanes
    logic [2*dsp_pkg::lane_count-1:0][dsp_pkg::code_w-1:0] code_win;
    dsp_pkg::est_t [dsp_pkg::lane_count-1:0]               est_d;
    dsp_pkg::est_t [dsp_pkg::lane_count-1:0]               est_q;
    dsp_pkg::bit_group_t                                   bits_d;
    dsp_pkg::bit_group_t                                   bits_q;
    dsp_pkg::bit_group_t                                   bits_prev_q;

    assign code_win = {cur_i.lane, prev_i.lane};

    always_comb begin
        dsp_pkg::ffe_acc_t acc;
        dsp_pkg::ffe_acc_t shifted;
        for (int l = 0; l < dsp_pkg::lane_count; l++) begin
            acc = '0;
            for (int k = 0; k < dsp_pkg::ffe_taps; k++) begin
                acc = acc
                    + dsp_pkg::ffe_acc_t'($signed(code_win[dsp_pkg::lane_count + l - k]))
                    * dsp_pkg::ffe_acc_t'($signed(cfg_i.ffe_w[k]));
            end
            shifted = acc >>> cfg_i.ffe_shift;
            // Saturate when the upper bits are not a sign extension
            if (&shifted[dsp_pkg::ffe_acc_w-1:dsp_pkg::est_w-1]
                    || ~|shifted[dsp_pkg::ffe_acc_w-1:dsp_pkg::est_w-1]) begin
                est_d[l] = shifted[dsp_pkg::est_w-1:0];
            end else if (shifted[dsp_pkg::ffe_acc_w-1]) begin
                est_d[l] = {1'b1, {(dsp_pkg::est_w-1){1'b0}}};
            end else begin
                est_d[l] = {1'b0, {(dsp_pkg::est_w-1){1'b1}}};
            end
        end
    end

    always_comb begin
        for (int l = 0; l < dsp_pkg::lane_count; l++) begin
            bits_d.lane[l] = $signed(est_q[l]) >= $signed(cfg_i.thresh);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            est_q       <= '0;
            bits_q      <= '0;
            bits_prev_q <= '0;
        end else begin
            est_q       <= est_d;
            bits_q      <= bits_d;
            bits_prev_q <= bits_q;
        end
    end

    assign bits_o      = bits_q;
    assign bits_prev_o = bits_prev_q;

endmodule

`default_nettype wire

/* hdl/sliding_detector.sv */
`default_nettype none

module sliding_detector (
    input  wire logic                clk,
    input  wire logic                rst_n_i,
    input  wire dsp_pkg::err_group_t err_i,
    input  wire dsp_pkg::bit_group_t bits_i,
    input  wire dsp_pkg::cfg_t       cfg_i,
    output dsp_pkg::det_group_t      det_o
);

    function automatic dsp_pkg::cost_t sq(input dsp_pkg::diff_t d);
        dsp_pkg::cost_t x;
        x = dsp_pkg::cost_t'(d);
        return x * x;
    endfunction

    dsp_pkg::err_group_t err_q;
    dsp_pkg::bit_group_t bits_q;
    dsp_pkg::det_group_t det_d;
    dsp_pkg::det_group_t det_q;
    dsp_pkg::weight_t    hs0;
    dsp_pkg::weight_t    hs1;
    dsp_pkg::diff_t      two_hs0;
    dsp_pkg::diff_t      two_hs1;

    // Held group in the low lanes, so lane 3 sees e[n+1] from the new group
    logic [2*dsp_pkg::lane_count-1:0][dsp_pkg::err_w-1:0] err_win;
    logic [2*dsp_pkg::lane_count-1:0]                     bit_win;

    assign err_win = {err_i.lane, err_q.lane};
    assign bit_win = {bits_i.lane, bits_q.lane};
    assign hs0     = $signed(cfg_i.chan_h[0]) >>> cfg_i.chan_shift;
    assign hs1     = $signed(cfg_i.chan_h[1]) >>> cfg_i.chan_shift;
    assign two_hs0 = dsp_pkg::diff_t'(hs0) <<< 1;
    assign two_hs1 = dsp_pkg::diff_t'(hs1) <<< 1;

    always_comb begin
        dsp_pkg::diff_t e0;
        dsp_pkg::diff_t e1;
        dsp_pkg::diff_t d_cur0;
        dsp_pkg::diff_t d_cur1;
        dsp_pkg::diff_t d_next1;
        dsp_pkg::cost_t c0;
        dsp_pkg::cost_t c1;
        dsp_pkg::cost_t c2;
        dsp_pkg::cost_t best;
        for (int l = 0; l < dsp_pkg::lane_count; l++) begin
            e0      = dsp_pkg::diff_t'($signed(err_win[l]));
            e1      = dsp_pkg::diff_t'($signed(err_win[l+1]));
            d_cur0  = bit_win[l] ? e0 - two_hs0 : e0 + two_hs0;
            d_cur1  = bit_win[l] ? e1 - two_hs1 : e1 + two_hs1;
            d_next1 = bit_win[l+1] ? e1 - two_hs0 : e1 + two_hs0;
            c0      = sq(e0) + sq(e1);
            c1      = sq(d_cur0) + sq(d_cur1);
            c2      = sq(e0) + sq(d_next1);
            // Strict compares keep the lower index on a tie
            best          = c0;
            det_d.lane[l] = dsp_pkg::det_none;
            if (c1 < best) begin
                best          = c1;
                det_d.lane[l] = dsp_pkg::det_flip_cur;
            end
            if (c2 < best) begin
                det_d.lane[l] = dsp_pkg::det_flip_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            err_q  <= '0;
            bits_q <= '0;
            det_q  <= '0;
        end else begin
            err_q  <= err_i;
            bits_q <= bits_i;
            det_q  <= det_d;
        end
    end

    assign det_o = det_q;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass line in the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_dsp_datapath

verilator --binary --top-module tb_dsp_datapath -f dsp_datapath.f --Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Verification passed$" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1

/* sim/tb_dsp_datapath.sv */
`default_nettype none

module tb_dsp_datapath;

    localparam int reset_cycles   = 16;
    localparam int n_tests        = 5;
    localparam int test_cycles    = 300;
    localparam int timeout_cycles = n_tests * test_cycles + reset_cycles + 200;
    localparam int max_samples    = 1024;
    localparam int lanes          = 4;
    localparam int pre_groups     = 2;
    localparam int post_groups    = 2;
    localparam int est_max        = (1 << (dsp_pkg::est_w - 1)) - 1;
    localparam int est_min        = -(1 << (dsp_pkg::est_w - 1));

    localparam logic [7:0] reg_addrs [4] = '{
        dsp_pkg::addr_ffe_w, dsp_pkg::addr_ffe_ctl, dsp_pkg::addr_chan_h, dsp_pkg::addr_chan_ctl
    };
    localparam logic [31:0] reg_masks [4] = '{
        32'h00FF_FFFF, 32'h03FF_0007, 32'h00FF_FFFF, 32'h0000_0007
    };

    logic                 clk;
    logic                 rst_n_i;
    logic [7:0]           paddr_i;
    logic                 psel_i;
    logic                 penable_i;
    logic                 pwrite_i;
    logic [31:0]          pwdata_i;
    logic [31:0]          prdata_o;
    logic                 pready_o;
    logic                 pslverr_o;
    dsp_pkg::code_group_t codes_i;
    logic                 codes_valid_i;
    dsp_pkg::bit_group_t  bits_o;
    dsp_pkg::err_group_t  err_o;
    dsp_pkg::det_group_t  det_o;
    logic                 out_valid_o;

    // Model state, one entry per sample
    int x_s [max_samples];
    int b_s [max_samples];
    int e_s [max_samples];
    int d_s [max_samples];

    int w [3];
    int h [3];
    int ffe_shift;
    int thresh;
    int chan_shift;

    int cyc;
    int checks;
    int errors;
    int test_num;
    int chk_mark;
    int err_mark;
    int first_in_cyc;
    int first_out_cyc;

    dsp_datapath_top dsp_datapath_top_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .paddr_i       (paddr_i),
        .psel_i        (psel_i),
        .penable_i     (penable_i),
        .pwrite_i      (pwrite_i),
        .pwdata_i      (pwdata_i),
        .prdata_o      (prdata_o),
        .pready_o      (pready_o),
        .pslverr_o     (pslverr_o),
        .codes_i       (codes_i),
        .codes_valid_i (codes_valid_i),
        .bits_o        (bits_o),
        .err_o         (err_o),
        .det_o         (det_o),
        .out_valid_o   (out_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // Watchdog
    initial begin
        cyc = 0;
        while (cyc < timeout_cycles) begin
            @(posedge clk);
            cyc++;
        end
        $display("TIMEOUT: run did not finish within %0d cycles", timeout_cycles);
        $display("Verification failed");
        $finish;
    end

    task automatic check(input string name, input int actual, input int expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED t=%0t %s: got %0d, expected %0d",
                     $time, name, actual, expected);
        end
    endtask

    task automatic end_test(input string name);
        test_num++;
        $display("test %0d %-20s checks %0d errors %0d",
                 test_num, name, checks - chk_mark, errors - err_mark);
        chk_mark = checks;
        err_mark = errors;
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic slverr);
        step();
        paddr_i   = addr;
        pwrite_i  = wr;
        pwdata_i  = wdata;
        psel_i    = 1'b1;
        penable_i = 1'b0;
        step();
        penable_i = 1'b1;
        @(negedge clk);
        check("pready_o", int'(pready_o), 1);
        rdata  = prdata_o;
        slverr = pslverr_o;
        step();
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic write_cfg();
        logic [31:0] d;
        logic [31:0] t;
        logic [31:0] rd;
        logic        slverr;
        d = '0;
        for (int k = 0; k < 3; k++) begin
            t = w[k];
            d[8*k +: 8] = t[7:0];
        end
        apb_access(1'b1, dsp_pkg::addr_ffe_w, d, rd, slverr);
        d = '0;
        t = ffe_shift;
        d[2:0] = t[2:0];
        t = thresh;
        d[25:16] = t[9:0];
        apb_access(1'b1, dsp_pkg::addr_ffe_ctl, d, rd, slverr);
        d = '0;
        for (int k = 0; k < 3; k++) begin
            t = h[k];
            d[8*k +: 8] = t[7:0];
        end
        apb_access(1'b1, dsp_pkg::addr_chan_h, d, rd, slverr);
        d = '0;
        t = chan_shift;
        d[2:0] = t[2:0];
        apb_access(1'b1, dsp_pkg::addr_chan_ctl, d, rd, slverr);
    endtask

    task automatic random_cfg(input int max_shift);
        logic [31:0] r;
        for (int k = 0; k < 3; k++) begin
            r    = $urandom;
            w[k] = int'($signed(r[7:0]));
            h[k] = int'($signed(r[15:8]));
        end
        r          = $urandom;
        thresh     = int'($signed(r[7:0]));
        ffe_shift  = $urandom_range(max_shift, 0);
        chan_shift = $urandom_range(max_shift, 0);
    endtask

    function automatic int code_at(input int n);
        if (n < 0) begin
            return 0;
        end
        return x_s[n];
    endfunction

    function automatic int sym_at(input int n);
        if (n < 0) begin
            return (0 >= thresh) ? 1 : -1;
        end
        return (b_s[n] != 0) ? 1 : -1;
    endfunction

    task automatic run_model(input int ns);
        int p;
        int est;
        int d0;
        int d1;
        int best;
        int hs [3];
        int c [3];
        for (int j = 0; j < 3; j++) begin
            hs[j] = h[j] >>> chan_shift;
        end
        for (int n = 0; n < ns; n++) begin
            p = 0;
            for (int k = 0; k < 3; k++) begin
                p += w[k] * code_at(n - k);
            end
            p = p >>> ffe_shift;
            if (p > est_max) begin
                p = est_max;
            end else if (p < est_min) begin
                p = est_min;
            end
            b_s[n] = (p >= thresh) ? 1 : 0;
        end
        for (int n = 0; n < ns; n++) begin
            est = 0;
            for (int j = 0; j < 3; j++) begin
                est += sym_at(n - j) * hs[j];
            end
            e_s[n] = est - code_at(n);
        end
        // Ties keep the lower index
        for (int n = 0; n < ns - 1; n++) begin
            c[0] = e_s[n] * e_s[n] + e_s[n+1] * e_s[n+1];
            d0   = e_s[n] - 2 * sym_at(n) * hs[0];
            d1   = e_s[n+1] - 2 * sym_at(n) * hs[1];
            c[1] = d0 * d0 + d1 * d1;
            d1   = e_s[n+1] - 2 * sym_at(n + 1) * hs[0];
            c[2] = e_s[n] * e_s[n] + d1 * d1;
            best = 0;
            for (int i = 1; i < 3; i++) begin
                if (c[i] < c[best]) begin
                    best = i;
                end
            end
            d_s[n] = best;
        end
    endtask

    task automatic sample_outputs(inout int out_idx, input int nv);
        int base;
        if (out_valid_o) begin
            if (out_idx >= nv) begin
                errors++;
                $display("ERROR t=%0t: out_valid_o high with no group in flight", $time);
            end else begin
                if (out_idx == 0) begin
                    first_out_cyc = cyc;
                end
                base = lanes * (out_idx + pre_groups);
                for (int l = 0; l < lanes; l++) begin
                    check($sformatf("bits_o[%0d]", l), int'(bits_o.lane[l]), b_s[base + l]);
                    check($sformatf("err_o[%0d]", l), int'($signed(err_o.lane[l])),
                          e_s[base + l]);
                    check($sformatf("det_o[%0d]", l), int'(det_o.lane[l]), d_s[base + l]);
                end
            end
            out_idx++;
        end
    endtask

    // Zero groups lead in, random trailing groups feed the lookahead of the last group
    task automatic run_stream(input int nv);
        int          ng;
        int          g;
        int          out_idx;
        logic [31:0] r;
        logic [31:0] v;
        ng = nv + pre_groups + post_groups;
        for (int n = 0; n < lanes * ng; n++) begin
            r = $urandom;
            x_s[n] = (n < lanes * pre_groups) ? 0 : int'($signed(r[7:0]));
        end
        run_model(lanes * ng);
        g       = 0;
        out_idx = 0;
        while (out_idx < nv) begin
            step();
            if (g < ng) begin
                for (int l = 0; l < lanes; l++) begin
                    v = x_s[lanes * g + l];
                    codes_i.lane[l] = v[7:0];
                end
                codes_valid_i = (g >= pre_groups) && (g < pre_groups + nv);
                if (g == pre_groups) begin
                    first_in_cyc = cyc;
                end
            end else begin
                codes_i       = '0;
                codes_valid_i = 1'b0;
            end
            g++;
            @(negedge clk);
            sample_outputs(out_idx, nv);
        end
        // Nothing may come out after the last valid group
        repeat (post_groups) begin
            step();
            @(negedge clk);
            sample_outputs(out_idx, nv);
        end
    endtask

    task automatic test_reg_access();
        logic [31:0] wdata [4];
        logic [31:0] rd;
        logic        slverr;
        check("out_valid_o", int'(out_valid_o), 0);
        for (int i = 0; i < 4; i++) begin
            apb_access(1'b0, reg_addrs[i], 32'h0, rd, slverr);
            check($sformatf("prdata_o @%02h", reg_addrs[i]), int'(rd), 0);
            check("pslverr_o", int'(slverr), 0);
        end
        for (int i = 0; i < 4; i++) begin
            wdata[i] = $urandom;
            apb_access(1'b1, reg_addrs[i], wdata[i], rd, slverr);
            check("pslverr_o", int'(slverr), 0);
        end
        for (int i = 0; i < 4; i++) begin
            apb_access(1'b0, reg_addrs[i], 32'h0, rd, slverr);
            check($sformatf("prdata_o @%02h", reg_addrs[i]), int'(rd),
                  int'(wdata[i] & reg_masks[i]));
        end
        apb_access(1'b0, 8'h10, 32'h0, rd, slverr);
        check("pslverr_o", int'(slverr), 1);
        check("prdata_o @10", int'(rd), 0);
        apb_access(1'b1, 8'h14, 32'hFFFF_FFFF, rd, slverr);
        check("pslverr_o", int'(slverr), 1);
        // A rejected write leaves every register as it was
        for (int i = 0; i < 4; i++) begin
            apb_access(1'b0, reg_addrs[i], 32'h0, rd, slverr);
            check($sformatf("prdata_o @%02h", reg_addrs[i]), int'(rd),
                  int'(wdata[i] & reg_masks[i]));
        end
        end_test("register access");
    endtask

    task automatic test_identity();
        w          = '{1, 0, 0};
        h          = '{0, 0, 0};
        ffe_shift  = 0;
        thresh     = 0;
        chan_shift = 0;
        write_cfg();
        run_stream(40);
        check("out_valid_o latency", first_out_cyc - first_in_cyc, 6);
        end_test("identity FFE");
    endtask

    task automatic test_random_ffe();
        random_cfg(3);
        write_cfg();
        run_stream(200);
        end_test("random FFE");
    endtask

    task automatic test_channel_error();
        random_cfg(7);
        write_cfg();
        run_stream(100);
        end_test("channel error");
    endtask

    task automatic test_detector();
        logic [31:0] r;
        random_cfg(2);
        write_cfg();
        run_stream(60);
        // h0 of zero makes C2 equal C0 on every sample
        r    = $urandom;
        h[0] = 0;
        h[1] = int'(r[5:0]) + 1;
        h[2] = int'($signed(r[15:8]));
        chan_shift = 0;
        write_cfg();
        run_stream(16);
        // All taps zero, three-way tie
        h = '{0, 0, 0};
        write_cfg();
        run_stream(16);
        end_test("detector");
    endtask

    initial begin
        void'($urandom(32'h8069));
        rst_n_i       = 1'b0;
        paddr_i       = '0;
        psel_i        = 1'b0;
        penable_i     = 1'b0;
        pwrite_i      = 1'b0;
        pwdata_i      = '0;
        codes_i       = '0;
        codes_valid_i = 1'b0;
        checks        = 0;
        errors        = 0;
        test_num      = 0;
        chk_mark      = 0;
        err_mark      = 0;
        first_in_cyc  = 0;
        first_out_cyc = 0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        test_reg_access();
        test_identity();
        test_random_ffe();
        test_channel_error();
        test_detector();

        $display("tests %0d, checks %0d, errors %0d", test_num, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
